// ==== verilog/osiris_pkg.sv ====
package osiris_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int DATA_W = 32;  // Memory word width
    localparam int MEM_AW = 10;  // Word address, 1024 entries per memory

    // ------------------------------------------------------------------------
    // Host protocol bytes
    // ------------------------------------------------------------------------

    localparam logic [7:0] CMD_WRITE = 8'h57;  // 'W' then 4 addr + 4 data bytes
    localparam logic [7:0] CMD_READ  = 8'h52;  // 'R' then 4 addr bytes
    localparam logic [7:0] REPLY_ACK = 8'h4B;  // 'K' sent back after a write

    // ------------------------------------------------------------------------
    // Wishbone bundles
    // ------------------------------------------------------------------------

    // Master to slave
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [MEM_AW-1:0] adr;  // Word address
        logic [DATA_W-1:0] dat;  // Write data
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;  // Read data, valid with ack
    } wb_rsp_t;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 434  // Clock cycles per serial bit, at least 4
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       start_rx_i,  // Receiver enable, line ignored while low
    input  logic       rx_i,        // Asynchronous serial input
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o   // One-cycle pulse per good frame
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state_q;
    logic [2:0]       line_q;   // [0] meta, [1] synced, [2] previous synced
    logic [CNT_W-1:0] cnt_q;    // Position inside the current bit
    logic [2:0]       bit_q;    // Data bit index
    logic [7:0]       shift_q;  // Received byte, LSB arrives first
    logic             valid_q;

    wire rx_s       = line_q[1];
    wire start_edge = line_q[2] & ~line_q[1];  // High to low on the synced line

    // Two-flop synchronizer plus one more stage for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            line_q <= 3'b111;  // Idle line is high
        end else begin
            line_q <= {line_q[1:0], rx_i};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (start_rx_i && start_edge) state_q <= RX_START;
                end
                RX_START: begin
                    if (cnt_q == HALF_END) begin  // Midpoint of the start bit
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= rx_s ? RX_IDLE : RX_DATA;  // Glitch if high again
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt_q == BIT_END) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) state_q <= RX_STOP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt_q == BIT_END) begin
                        valid_q <= rx_s;  // Framing error drops the byte
                        state_q <= RX_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Sample data bits at their midpoints
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && cnt_q == BIT_END) shift_q <= {rx_s, shift_q[7:1]};
    end

    assign rx_data_o  = shift_q;
    assign rx_valid_o = valid_q;

    // A full frame separates two bytes
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        rx_valid_o |=> !rx_valid_o);

endmodule

// ==== verilog/uart_wb_master.sv ====
`timescale 1ns/1ps

module uart_wb_master (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [7:0]          rx_data_i,
    input  logic                rx_valid_i,
    input  logic                tx_busy_i,
    output logic [7:0]          tx_data_o,
    output logic                tx_start_o,
    output osiris_pkg::wb_req_t wb_req_o,
    input  osiris_pkg::wb_rsp_t wb_rsp_i
);

    import osiris_pkg::*;

    typedef enum logic [2:0] {ST_CMD, ST_ADDR, ST_DATA, ST_BUS, ST_REPLY} state_t;

    state_t            state_q;
    logic              is_write_q;  // Command of the frame in progress
    logic [1:0]        cnt_q;       // Byte counter, also bytes left in the reply
    logic [MEM_AW-1:0] addr_q;      // Low address bits only
    logic [DATA_W-1:0] data_q;      // Write data, then read word for the reply
    logic              cyc_q;       // cyc and stb move together
    logic              first_q;     // First cycle of a bus cycle
    logic              tx_start_q;
    logic [7:0]        tx_data_q;

    // Ack in the first bus cycle belongs to the core that owned the memory before
    wire bus_ack = cyc_q && !first_q && wb_rsp_i.ack;
    wire tx_ok   = !tx_busy_i && !tx_start_q;  // Busy rises one cycle after start

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= ST_CMD;
            is_write_q <= 1'b0;
            cnt_q      <= '0;
            cyc_q      <= 1'b0;
            first_q    <= 1'b0;
            tx_start_q <= 1'b0;
        end else begin
            tx_start_q <= 1'b0;
            case (state_q)
                ST_CMD: begin
                    cnt_q <= '0;
                    if (rx_valid_i) begin
                        if (rx_data_i == CMD_WRITE) begin
                            is_write_q <= 1'b1;
                            state_q    <= ST_ADDR;
                        end else if (rx_data_i == CMD_READ) begin
                            is_write_q <= 1'b0;
                            state_q    <= ST_ADDR;
                        end  // Anything else is dropped
                    end
                end
                ST_ADDR: begin
                    if (rx_valid_i) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == 2'd3) begin
                            if (is_write_q) begin
                                state_q <= ST_DATA;
                            end else begin
                                cyc_q   <= 1'b1;
                                first_q <= 1'b1;
                                state_q <= ST_BUS;
                            end
                        end
                    end
                end
                ST_DATA: begin
                    if (rx_valid_i) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == 2'd3) begin
                            cyc_q   <= 1'b1;
                            first_q <= 1'b1;
                            state_q <= ST_BUS;
                        end
                    end
                end
                ST_BUS: begin
                    first_q <= 1'b0;
                    if (bus_ack) begin
                        cyc_q   <= 1'b0;
                        cnt_q   <= is_write_q ? 2'd0 : 2'd3;  // Reply length minus one
                        state_q <= ST_REPLY;
                    end
                end
                ST_REPLY: begin
                    if (tx_ok) begin
                        tx_start_q <= 1'b1;
                        cnt_q      <= cnt_q - 1'b1;
                        if (cnt_q == 2'd0) state_q <= ST_CMD;
                    end
                end
                default: state_q <= ST_CMD;
            endcase
        end
    end

    // Payload path, no reset needed
    always_ff @(posedge clk) begin
        if (rx_valid_i && state_q == ST_ADDR) begin
            addr_q <= MEM_AW'({addr_q, rx_data_i});  // MSB first, upper bits fall off
        end
        if (rx_valid_i && state_q == ST_DATA) begin
            data_q <= {data_q[DATA_W-9:0], rx_data_i};
        end else if (bus_ack && !is_write_q) begin
            data_q <= wb_rsp_i.dat;  // Capture read word
        end else if (state_q == ST_REPLY && tx_ok) begin
            data_q <= data_q << 8;  // Next byte to the top
        end
        if (state_q == ST_REPLY && tx_ok) begin
            tx_data_q <= is_write_q ? REPLY_ACK : data_q[DATA_W-1 -: 8];
        end
    end

    assign wb_req_o = '{cyc: cyc_q, stb: cyc_q, we: is_write_q, adr: addr_q, dat: data_q};
    assign tx_data_o  = tx_data_q;
    assign tx_start_o = tx_start_q;

    // Reply path back-pressure
    a_tx_no_overrun: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_start_o |-> !tx_busy_i);

    // Request held until acknowledged
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_req_o.stb && !wb_rsp_i.ack |=> $stable(wb_req_o));

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 434  // Clock cycles per serial bit
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic [7:0] tx_data_i,
    input  logic       tx_start_i,  // Accepted only while idle
    output logic       tx_o,
    output logic       tx_busy_o    // Covers start, data and stop bits
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    logic             busy_q;
    logic             line_q;   // Registered line, no glitches
    logic [CNT_W-1:0] cnt_q;    // Bit-period counter
    logic [3:0]       bit_q;    // 0 is the start bit, 9 the stop bit
    logic [8:0]       shift_q;  // Data bits then stop bit

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            line_q <= 1'b1;
            cnt_q  <= '0;
            bit_q  <= '0;
        end else if (!busy_q) begin
            cnt_q <= '0;
            bit_q <= '0;
            if (tx_start_i) begin
                busy_q <= 1'b1;
                line_q <= 1'b0;  // Start bit
            end
        end else if (cnt_q == BIT_END) begin
            cnt_q <= '0;
            if (bit_q == 4'd9) begin
                busy_q <= 1'b0;  // End of stop bit, line already high
            end else begin
                line_q <= shift_q[0];
                bit_q  <= bit_q + 1'b1;
            end
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Shift register, ones fill in behind the stop bit
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!busy_q && tx_start_i) begin
            shift_q <= {1'b1, tx_data_i};
        end else if (busy_q && cnt_q == BIT_END) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    assign tx_o      = line_q;
    assign tx_busy_o = busy_q;

endmodule

// ==== verilog/mem_router.sv ====
`timescale 1ns/1ps

module mem_router (
    input  logic                          select_mem_i,  // 0 instruction, 1 data memory
    input  osiris_pkg::wb_req_t           bridge_req_i,
    output osiris_pkg::wb_rsp_t           bridge_rsp_o,
    input  logic [osiris_pkg::MEM_AW-1:0] core_pc_i,
    input  logic [osiris_pkg::MEM_AW-1:0] core_daddr_i,
    input  logic                          core_dwe_i,
    input  logic [osiris_pkg::DATA_W-1:0] core_wdata_i,
    output logic [osiris_pkg::DATA_W-1:0] core_instr_o,
    output logic [osiris_pkg::DATA_W-1:0] core_rdata_o,
    output osiris_pkg::wb_req_t           imem_req_o,
    output osiris_pkg::wb_req_t           dmem_req_o,
    input  osiris_pkg::wb_rsp_t           imem_rsp_i,
    input  osiris_pkg::wb_rsp_t           dmem_rsp_i
);

    // Bridge owns a memory only during its own bus cycle
    wire bridge_imem = bridge_req_i.cyc && !select_mem_i;
    wire bridge_dmem = bridge_req_i.cyc && select_mem_i;

    always_comb begin
        // Fetch port, read only
        imem_req_o = bridge_imem ? bridge_req_i
                   : '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: core_pc_i, dat: core_wdata_i};
        // Load/store port
        dmem_req_o = bridge_dmem ? bridge_req_i
                   : '{cyc: 1'b1, stb: 1'b1, we: core_dwe_i, adr: core_daddr_i,
                       dat: core_wdata_i};

        bridge_rsp_o.ack = bridge_req_i.cyc && (select_mem_i ? dmem_rsp_i.ack
                                                              : imem_rsp_i.ack);
        bridge_rsp_o.dat = select_mem_i ? dmem_rsp_i.dat : imem_rsp_i.dat;
    end

    assign core_instr_o = imem_rsp_i.dat;  // Always the fetch result
    assign core_rdata_o = dmem_rsp_i.dat;

    // Bridge ack only from the memory that currently carries the bridge cycle
    always_comb begin
        if (bridge_rsp_o.ack === 1'b1) begin
            a_ack_source: assert final (select_mem_i ? (dmem_req_o === bridge_req_i)
                                                     : (imem_req_o === bridge_req_i));
        end
    end

endmodule

// ==== verilog/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram (
    input  logic                clk,
    input  logic                rst_n_i,
    input  osiris_pkg::wb_req_t req_i,
    output osiris_pkg::wb_rsp_t rsp_o
);

    import osiris_pkg::*;

    logic [DATA_W-1:0] mem_q [0:(1 << MEM_AW) - 1];  // Contents undefined until written
    logic              ack_q;
    logic [DATA_W-1:0] rdata_q;

    wire req_hit = req_i.cyc && req_i.stb && !ack_q;  // New request, nothing pending

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_hit;  // One-cycle pulse
        end
    end

    // Core port streams every cycle, so write and read do not wait for the ack slot
    always_ff @(posedge clk) begin
        if (req_i.cyc && req_i.stb && req_i.we) mem_q[req_i.adr] <= req_i.dat;
        rdata_q <= mem_q[req_i.adr];  // Old data on a write to the same word
    end

    assign rsp_o = '{ack: ack_q, dat: rdata_q};

    a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_o.ack |-> $past(req_i.cyc && req_i.stb));

endmodule

// ==== verilog/osiris_loader.sv ====
`timescale 1ns/1ps

module osiris_loader #(
    parameter int CLOCK_FREQ = 50_000_000,  // Hz
    parameter int BAUD_RATE  = 115_200
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          uart_rx_i,
    input  logic                          start_rx_i,    // Receiver enable
    input  logic                          select_mem_i,  // 0 instruction, 1 data memory
    output logic                          uart_tx_o,
    input  logic [osiris_pkg::MEM_AW-1:0] core_pc_i,
    output logic [osiris_pkg::DATA_W-1:0] core_instr_o,
    input  logic [osiris_pkg::MEM_AW-1:0] core_daddr_i,
    input  logic                          core_dwe_i,
    input  logic [osiris_pkg::DATA_W-1:0] core_wdata_i,
    output logic [osiris_pkg::DATA_W-1:0] core_rdata_o
);

    import osiris_pkg::*;

    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    wb_req_t    bridge_req;
    wb_rsp_t    bridge_rsp;
    wb_req_t    imem_req;
    wb_rsp_t    imem_rsp;
    wb_req_t    dmem_req;
    wb_rsp_t    dmem_rsp;

    // ------------------------------------------------------------------------
    // Serial side and command decoder
    // ------------------------------------------------------------------------
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
        .clk(clk), .rst_n_i(rst_n_i), .start_rx_i(start_rx_i), .rx_i(uart_rx_i),
        .rx_data_o(rx_data), .rx_valid_o(rx_valid)
    );

    uart_wb_master uart_wb_master_inst (
        .clk(clk), .rst_n_i(rst_n_i), .rx_data_i(rx_data), .rx_valid_i(rx_valid),
        .tx_busy_i(tx_busy), .tx_data_o(tx_data), .tx_start_o(tx_start),
        .wb_req_o(bridge_req), .wb_rsp_i(bridge_rsp)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
        .clk(clk), .rst_n_i(rst_n_i), .tx_data_i(tx_data), .tx_start_i(tx_start),
        .tx_o(uart_tx_o), .tx_busy_o(tx_busy)
    );

    // ------------------------------------------------------------------------
    // Memory side
    // ------------------------------------------------------------------------
    mem_router mem_router_inst (
        .select_mem_i(select_mem_i), .bridge_req_i(bridge_req), .bridge_rsp_o(bridge_rsp),
        .core_pc_i(core_pc_i), .core_daddr_i(core_daddr_i), .core_dwe_i(core_dwe_i),
        .core_wdata_i(core_wdata_i), .core_instr_o(core_instr_o),
        .core_rdata_o(core_rdata_o), .imem_req_o(imem_req), .dmem_req_o(dmem_req),
        .imem_rsp_i(imem_rsp), .dmem_rsp_i(dmem_rsp)
    );

    wb_ram imem_inst (.clk(clk), .rst_n_i(rst_n_i), .req_i(imem_req), .rsp_o(imem_rsp));

    wb_ram dmem_inst (.clk(clk), .rst_n_i(rst_n_i), .req_i(dmem_req), .rsp_o(dmem_rsp));

endmodule

// ==== testbench/tb_osiris_loader.sv ====
`timescale 1ns/1ps

module tb_osiris_loader;

    // Host protocol bytes
    localparam logic [7:0] WR_CMD   = 8'h57;
    localparam logic [7:0] RD_CMD   = 8'h52;
    localparam logic [7:0] ACK_BYTE = 8'h4B;
    localparam logic [7:0] JUNK     = 8'hA5;  // Neither command
    localparam int N_WORDS  = 8;              // Words per test step
    localparam int N_FRAMES = 56 * N_WORDS + 40;  // Both directions plus idle checks
    localparam longint TIMEOUT_NS = 2 * N_FRAMES * 11 * 10 * 20;

    logic        clk;
    logic        rst_n_i;
    logic        uart_rx_i;
    logic        start_rx_i;
    logic        select_mem_i;
    logic        uart_tx_o;
    logic [9:0]  core_pc_i;
    logic [31:0] core_instr_o;
    logic [9:0]  core_daddr_i;
    logic        core_dwe_i;
    logic [31:0] core_wdata_i;
    logic [31:0] core_rdata_o;

    logic [31:0] lfsr_q;                  // Random source state
    logic [31:0] imem_model [0:1023];
    logic [31:0] dmem_model [0:1023];
    logic [9:0]  addr_list [0:N_WORDS-1];
    logic [9:0]  core_addr [0:N_WORDS-1];  // Addresses written by the core
    logic [31:0] got_q [$];                // Results waiting for the compare process
    logic [31:0] exp_q [$];
    string       what_q [$];

    osiris_loader #(.CLOCK_FREQ(50_000_000), .BAUD_RATE(5_000_000)) osiris_loader_inst (
        .clk(clk), .rst_n_i(rst_n_i), .uart_rx_i(uart_rx_i), .start_rx_i(start_rx_i),
        .select_mem_i(select_mem_i), .uart_tx_o(uart_tx_o), .core_pc_i(core_pc_i),
        .core_instr_o(core_instr_o), .core_daddr_i(core_daddr_i), .core_dwe_i(core_dwe_i),
        .core_wdata_i(core_wdata_i), .core_rdata_o(core_rdata_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 50 MHz

    // -------------------------------------------------------------------------
    // Random numbers and reference model
    // -------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_step(lfsr_q);  // One step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] expected_word(input logic sel, input logic [9:0] addr);
        return sel ? dmem_model[addr] : imem_model[addr];
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic push_result(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
    endtask

    // Drains the result queues once per cycle
    always @(negedge clk) begin
        while (got_q.size() > 0) compare(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
    end

    // -------------------------------------------------------------------------
    // UART host model, 10 clocks per bit
    // -------------------------------------------------------------------------
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};  // Stop, data LSB first, start
        for (i = 0; i < 10; i++) begin
            uart_rx_i = frame[i];
            repeat (10) @(negedge clk);
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        send_byte(w[31:24]);  // MSB first
        send_byte(w[23:16]);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
    endtask

    task automatic receive_byte(output logic [7:0] b);
        int i;
        @(negedge uart_tx_o);
        repeat (5) @(negedge clk);  // Middle of the start bit
        compare({31'd0, uart_tx_o}, 32'd0, "reply start bit");
        for (i = 0; i < 8; i++) begin
            repeat (10) @(negedge clk);
            b = {uart_tx_o, b[7:1]};
        end
        repeat (10) @(negedge clk);
        compare({31'd0, uart_tx_o}, 32'd1, "reply stop bit");
    endtask

    task automatic receive_word(output logic [31:0] w);
        logic [7:0] b;
        int         i;
        w = '0;
        for (i = 0; i < 4; i++) begin
            receive_byte(b);
            w = {w[23:0], b};
        end
    endtask

    // Upper address bits carry random junk, only bits 9..0 count
    task automatic send_write(input logic [9:0] addr, input logic [31:0] data);
        send_byte(WR_CMD);
        send_word((random_bits(22) << 10) | addr);
        send_word(data);
    endtask

    task automatic write_word(input logic sel, input logic [9:0] addr, input logic [31:0] data);
        logic [7:0] reply;
        @(negedge clk);
        select_mem_i = sel;
        fork
            send_write(addr, data);
            receive_byte(reply);
        join
        push_result({24'd0, reply}, {24'd0, ACK_BYTE}, "write reply");
        if (sel) dmem_model[addr] = data;
        else     imem_model[addr] = data;
    endtask

    task automatic read_word(input logic sel, input logic [9:0] addr, input string what);
        logic [31:0] got;
        @(negedge clk);
        select_mem_i = sel;
        fork
            begin
                send_byte(RD_CMD);
                send_word((random_bits(22) << 10) | addr);
            end
            receive_word(got);
        join
        push_result(got, expected_word(sel, addr), what);
    endtask

    // -------------------------------------------------------------------------
    // Test sequence
    // -------------------------------------------------------------------------
    initial begin
        logic [31:0] data;
        int          i;
        uart_rx_i    = 1'b1;  // Line idles high
        start_rx_i   = 1'b1;
        select_mem_i = 1'b0;
        core_pc_i    = '0;
        core_daddr_i = '0;
        core_dwe_i   = 1'b0;
        core_wdata_i = '0;
        lfsr_q       = 32'hcf70_5afd;
        rst_n_i      = 1'b0;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;

        repeat (200) begin  // Quiet host, quiet reply line
            @(negedge clk);
            compare({31'd0, uart_tx_o}, 32'd1, "idle line after reset");
        end

        for (i = 0; i < N_WORDS; i++) begin
            addr_list[i] = random_bits(10);
            write_word(1'b0, addr_list[i], random_bits(32));
        end
        for (i = 0; i < N_WORDS; i++) read_word(1'b0, addr_list[i], "imem read back");

        // Same addresses in the data memory
        for (i = 0; i < N_WORDS; i++) write_word(1'b1, addr_list[i], random_bits(32));
        for (i = 0; i < N_WORDS; i++) begin
            read_word(1'b0, addr_list[i], "imem after dmem writes");
            read_word(1'b1, addr_list[i], "dmem read back");
        end

        // Core ports while the bridge is idle
        for (i = 0; i < N_WORDS; i++) begin
            @(negedge clk);
            core_pc_i = addr_list[i];
            @(negedge clk);
            push_result(core_instr_o, expected_word(1'b0, addr_list[i]), "core fetch");
        end
        for (i = 0; i < N_WORDS; i++) begin
            core_addr[i] = random_bits(10);
            data         = random_bits(32);
            @(negedge clk);
            core_daddr_i = core_addr[i];
            core_wdata_i = data;
            core_dwe_i   = 1'b1;
            @(negedge clk);
            core_dwe_i = 1'b0;  // Write landed at the last edge
            dmem_model[core_addr[i]] = data;
            @(negedge clk);
            push_result(core_rdata_o, expected_word(1'b1, core_addr[i]), "core data read");
        end
        for (i = 0; i < N_WORDS; i++) read_word(1'b1, core_addr[i], "dmem after core write");

        // Receiver disabled, whole frame must vanish
        @(negedge clk);
        start_rx_i   = 1'b0;
        select_mem_i = 1'b0;
        send_write(addr_list[0], ~expected_word(1'b0, addr_list[0]));
        repeat (20) @(negedge clk);
        start_rx_i = 1'b1;
        read_word(1'b0, addr_list[0], "imem after ignored frame");
        @(negedge clk);
        send_byte(JUNK);  // Dropped by the decoder
        write_word(1'b0, addr_list[1], random_bits(32));
        read_word(1'b0, addr_list[1], "read after stray byte");

        repeat (2) @(negedge clk);
        if (got_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "Some results were never compared");
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Something failed");
        $fatal(1, "Timeout: the run did not finish in the expected time");
    end

endmodule

// ==== all.f ====
verilog/osiris_pkg.sv
verilog/uart_rx.sv
verilog/uart_wb_master.sv
verilog/uart_tx.sv
verilog/mem_router.sv
verilog/wb_ram.sv
verilog/osiris_loader.sv
testbench/tb_osiris_loader.sv

// ==== Bender.yml ====
package:
  name: osiris_loader

sources:
  # Package first, then the blocks, then the top level
  - verilog/osiris_pkg.sv
  - verilog/uart_rx.sv
  - verilog/uart_wb_master.sv
  - verilog/uart_tx.sv
  - verilog/mem_router.sv
  - verilog/wb_ram.sv
  - verilog/osiris_loader.sv

  - target: simulation
    files:
      - testbench/tb_osiris_loader.sv
